// File: rtl/pcs_defs.svh
// ========================================
// Constants for the 10GBASE-R receive PCS
// Lock thresholds and XGMII control codes
// Include wherever these values are used
// ========================================
`ifndef PCS_DEFS_SVH
`define PCS_DEFS_SVH

// Consecutive good headers needed for lock
`define PCS_LOCK_GOOD_CNT 64
// Header window checked while locked
`define PCS_LOCK_WINDOW 64
// Bad headers per window that drop lock
`define PCS_LOCK_BAD_MAX 16
// Valid words ignored after a gearbox slip
`define PCS_SLIP_WAIT 32

// XGMII control characters
`define PCS_XGMII_IDLE 8'h07
`define PCS_XGMII_START 8'hfb
`define PCS_XGMII_TERM 8'hfd
`define PCS_XGMII_ERROR 8'hfe

`endif

// File: rtl/pcs_pkg.sv
// ========================================
// Shared types of the receive PCS
// Word structs and the lock state machine
// ========================================
package pcs_pkg;

    // 01 is data, 10 is control
    typedef logic [1:0] sync_hdr_t;
    typedef logic [63:0] blk_payload_t;
    // Lane 0 sits in bits 7:0
    typedef logic [63:0] xgmii_data_t;
    typedef logic [7:0] xgmii_ctrl_t;
    typedef logic [15:0] err_count_t;

    // Word from the transceiver gearbox
    typedef struct packed {
        sync_hdr_t hdr;
        blk_payload_t payload;
        logic valid;
    } gt_rx_word_t;

    // Block after descrambling
    typedef struct packed {
        sync_hdr_t hdr;
        blk_payload_t payload;
        logic valid;
    } pcs_block_t;

    typedef struct packed {
        xgmii_data_t data;
        xgmii_ctrl_t ctrl;
        logic valid;
    } xgmii_word_t;

    typedef enum logic [1:0] {
        lock_hunt,
        lock_slip_wait,
        lock_locked
    } lock_state_t;

endpackage

// File: rtl/rx_block_lock.sv
// ========================================
// Block lock for 64b/66b sync headers
// Hunts for lock and pulses gearbox slip
// Watches the raw gearbox words
// ========================================
`timescale 1ns/1ns
`include "pcs_defs.svh"

module rx_block_lock import pcs_pkg::*; (
    input  logic        gt_rxusrclk,
    input  logic        gt_tx_reset,
    input  gt_rx_word_t gt_rx,
    output logic        gearbox_slip,
    output logic        block_lock
);

    localparam int good_w = $clog2(`PCS_LOCK_GOOD_CNT);
    localparam int win_w = $clog2(`PCS_LOCK_WINDOW);
    localparam int bad_w = $clog2(`PCS_LOCK_BAD_MAX);
    localparam int wait_w = $clog2(`PCS_SLIP_WAIT);

    localparam logic [good_w-1:0] good_last = good_w'(`PCS_LOCK_GOOD_CNT - 1);
    localparam logic [win_w-1:0] win_last = win_w'(`PCS_LOCK_WINDOW - 1);
    localparam logic [bad_w-1:0] bad_last = bad_w'(`PCS_LOCK_BAD_MAX - 1);
    localparam logic [wait_w-1:0] wait_last = wait_w'(`PCS_SLIP_WAIT - 1);

    lock_state_t state;
    logic [good_w-1:0] good_cnt;
    logic [win_w-1:0] win_cnt;
    logic [bad_w-1:0] bad_cnt;
    logic [wait_w-1:0] wait_cnt;
    logic hdr_ok;

    // Only 01 and 10 are legal headers
    assign hdr_ok = gt_rx.hdr[1] ^ gt_rx.hdr[0];

    // Lock follows the state register directly
    assign block_lock = (state == lock_locked);

    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            state <= lock_hunt;
            good_cnt <= '0;
            win_cnt <= '0;
            bad_cnt <= '0;
            wait_cnt <= '0;
            gearbox_slip <= 1'b0;
        end else begin
            gearbox_slip <= 1'b0;
            if (gt_rx.valid) begin
                case (state)
                    lock_hunt: begin
                        if (!hdr_ok) begin
                            gearbox_slip <= 1'b1;
                            good_cnt <= '0;
                            wait_cnt <= '0;
                            state <= lock_slip_wait;
                        end else if (good_cnt == good_last) begin
                            good_cnt <= '0;
                            win_cnt <= '0;
                            bad_cnt <= '0;
                            state <= lock_locked;
                        end else begin
                            good_cnt <= good_cnt + 1'b1;
                        end
                    end
                    lock_slip_wait: begin
                        // Let the gearbox settle on the new alignment
                        if (wait_cnt == wait_last) begin
                            wait_cnt <= '0;
                            state <= lock_hunt;
                        end else begin
                            wait_cnt <= wait_cnt + 1'b1;
                        end
                    end
                    lock_locked: begin
                        if (!hdr_ok && bad_cnt == bad_last) begin
                            gearbox_slip <= 1'b1;
                            wait_cnt <= '0;
                            state <= lock_slip_wait;
                        end else if (win_cnt == win_last) begin
                            // Window done, start a fresh count
                            win_cnt <= '0;
                            bad_cnt <= '0;
                        end else begin
                            win_cnt <= win_cnt + 1'b1;
                            if (!hdr_ok) begin
                                bad_cnt <= bad_cnt + 1'b1;
                            end
                        end
                    end
                    default: begin
                        state <= lock_hunt;
                    end
                endcase
            end
        end
    end

endmodule

// File: rtl/rx_descrambler.sv
// ========================================
// Self-synchronous descrambler, x^58+x^39+1
// One registered stage, header passes as is
// ========================================
`timescale 1ns/1ns

module rx_descrambler import pcs_pkg::*; (
    input  logic        gt_rxusrclk,
    input  logic        gt_tx_reset,
    input  gt_rx_word_t gt_rx,
    output pcs_block_t  desc_blk
);

    // Last 58 received bits, bit 57 is the newest
    logic [57:0] scr_state;
    logic [121:0] rx_hist;
    blk_payload_t desc_data;
    blk_payload_t payload_q;
    sync_hdr_t hdr_q;
    logic valid_q;

    // Oldest bits at the bottom, bit 0 of the word follows the state
    assign rx_hist = {gt_rx.payload, scr_state};

    always_comb begin
        for (int i = 0; i < 64; i++) begin
            desc_data[i] = rx_hist[58 + i] ^ rx_hist[19 + i] ^ rx_hist[i];
        end
    end

    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            scr_state <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= gt_rx.valid;
            if (gt_rx.valid) begin
                scr_state <= rx_hist[121:64];
            end
        end
    end

    always_ff @(posedge gt_rxusrclk) begin
        hdr_q <= gt_rx.hdr;
        payload_q <= desc_data;
    end

    assign desc_blk = '{hdr: hdr_q, payload: payload_q, valid: valid_q};

endmodule

// File: rtl/rx_block_decoder.sv
// ========================================
// 64b/66b block decoder onto the XGMII
// Unsupported blocks become error words
// and bump a saturating error counter
// ========================================
`timescale 1ns/1ns
`include "pcs_defs.svh"

module rx_block_decoder import pcs_pkg::*; (
    input  logic        gt_rxusrclk,
    input  logic        gt_tx_reset,
    input  pcs_block_t  desc_blk,
    input  logic        block_lock,
    output xgmii_word_t xgmii,
    output err_count_t  error_count
);

    localparam sync_hdr_t hdr_data = 2'b01;

    // Supported block type bytes
    localparam logic [7:0] type_idle = 8'h1e;
    localparam logic [7:0] type_start = 8'h78;
    localparam logic [7:0] type_term0 = 8'h87;
    localparam logic [7:0] type_term7 = 8'hff;

    xgmii_data_t dec_data;
    xgmii_ctrl_t dec_ctrl;
    logic dec_err;
    xgmii_data_t data_q;
    xgmii_ctrl_t ctrl_q;
    logic valid_q;

    always_comb begin
        dec_data = {8{`PCS_XGMII_ERROR}};
        dec_ctrl = 8'hff;
        dec_err = 1'b0;
        if (!block_lock) begin
            dec_err = 1'b1;
        end else if (desc_blk.hdr == hdr_data) begin
            dec_data = desc_blk.payload;
            dec_ctrl = 8'h00;
        end else begin
            case (desc_blk.payload[7:0])
                type_idle: begin
                    dec_data = {8{`PCS_XGMII_IDLE}};
                end
                type_start: begin
                    dec_data = {desc_blk.payload[63:8], `PCS_XGMII_START};
                    dec_ctrl = 8'h01;
                end
                type_term0: begin
                    dec_data = {{7{`PCS_XGMII_IDLE}}, `PCS_XGMII_TERM};
                end
                type_term7: begin
                    // Seven data bytes shift down one lane
                    dec_data = {`PCS_XGMII_TERM, desc_blk.payload[63:8]};
                    dec_ctrl = 8'h80;
                end
                default: begin
                    dec_err = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge gt_rxusrclk or posedge gt_tx_reset) begin
        if (gt_tx_reset) begin
            valid_q <= 1'b0;
            error_count <= '0;
        end else begin
            valid_q <= desc_blk.valid;
            // Counter sticks at its maximum
            if (desc_blk.valid && dec_err && error_count != '1) begin
                error_count <= error_count + 1'b1;
            end
        end
    end

    always_ff @(posedge gt_rxusrclk) begin
        data_q <= dec_data;
        ctrl_q <= dec_ctrl;
    end

    assign xgmii = '{data: data_q, ctrl: ctrl_q, valid: valid_q};

endmodule

// File: rtl/sfp_rx_pcs.sv
// ========================================
// Receive PCS for one SFP+ port
// Gearbox words in, XGMII words out
// ========================================
`timescale 1ns/1ns

module sfp_rx_pcs import pcs_pkg::*; (
    input  logic        gt_rxusrclk,
    input  logic        gt_tx_reset,
    input  gt_rx_word_t gt_rx,
    output logic        gearbox_slip,
    output logic        block_lock,
    output xgmii_word_t xgmii,
    output err_count_t  error_count
);

    pcs_block_t desc_blk;

    // Lock runs beside the data path on the raw words
    rx_block_lock i_rx_block_lock (
        .gt_rxusrclk  (gt_rxusrclk),
        .gt_tx_reset  (gt_tx_reset),
        .gt_rx        (gt_rx),
        .gearbox_slip (gearbox_slip),
        .block_lock   (block_lock)
    );

    rx_descrambler i_rx_descrambler (
        .gt_rxusrclk (gt_rxusrclk),
        .gt_tx_reset (gt_tx_reset),
        .gt_rx       (gt_rx),
        .desc_blk    (desc_blk)
    );

    // Lock status lines up with the word one stage later
    rx_block_decoder i_rx_block_decoder (
        .gt_rxusrclk (gt_rxusrclk),
        .gt_tx_reset (gt_tx_reset),
        .desc_blk    (desc_blk),
        .block_lock  (block_lock),
        .xgmii       (xgmii),
        .error_count (error_count)
    );

endmodule

// File: dv/tb_clk_gen.sv
// ========================================
// Testbench clock and reset source
// 4 ns clock, reset held for 4 cycles
// ========================================
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: dv/sfp_rx_pcs_tb.sv
// ========================================
// Directed testbench for the receive PCS
// Scrambles blocks, checks XGMII and lock
// ========================================
`timescale 1ns/1ns
`include "pcs_defs.svh"

module sfp_rx_pcs_tb import pcs_pkg::*; ();

    logic gt_rxusrclk;
    logic gt_tx_reset;
    gt_rx_word_t gt_rx;
    logic gearbox_slip;
    logic block_lock;
    xgmii_word_t xgmii;
    err_count_t error_count;

    logic [31:0] rng_state;
    // Bit 0 is the newest scrambled bit
    logic [57:0] tx_hist;
    int cyc;
    int win_pos;
    int exp_errors;
    xgmii_word_t exp_q[$];
    int due_q[$];
    logic [7:0] ctrl_types [4] = '{8'h1e, 8'h78, 8'h87, 8'hff};

    tb_clk_gen i_tb_clk_gen (.clk(gt_rxusrclk), .rst(gt_tx_reset));

    sfp_rx_pcs i_sfp_rx_pcs (
        .gt_rxusrclk  (gt_rxusrclk),
        .gt_tx_reset  (gt_tx_reset),
        .gt_rx        (gt_rx),
        .gearbox_slip (gearbox_slip),
        .block_lock   (block_lock),
        .xgmii        (xgmii),
        .error_count  (error_count)
    );

    always @(posedge gt_rxusrclk) begin
        cyc <= cyc + 1;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_xgmii(input string name, input xgmii_word_t got, input xgmii_word_t exp);
        if (got !== exp) begin
            fail_now($sformatf("ERROR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input err_count_t got, input err_count_t exp);
        if (got !== exp) begin
            fail_now($sformatf("ERROR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("ERROR %s got %h expected %h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic rand64(output logic [63:0] r);
        rng_state = xorshift32(rng_state);
        r[31:0] = rng_state;
        rng_state = xorshift32(rng_state);
        r[63:32] = rng_state;
    endtask

    // Transmit side scrambler sending bit 0 first
    task automatic scramble(input blk_payload_t plain, output blk_payload_t scr);
        for (int i = 0; i < 64; i++) begin
            scr[i] = plain[i] ^ tx_hist[38] ^ tx_hist[57];
            tx_hist = {tx_hist[56:0], scr[i]};
        end
    endtask

    // Expected XGMII word for a block and the lock seen at decode
    function automatic xgmii_word_t decode_expect(input sync_hdr_t hdr, input blk_payload_t p,
                                                  input logic locked);
        logic [7:0] lanes [8];
        xgmii_word_t w;
        lanes = '{default: `PCS_XGMII_ERROR};
        w.ctrl = 8'hff;
        if (locked && hdr == 2'b01) begin
            for (int i = 0; i < 8; i++) begin
                lanes[i] = p[8*i +: 8];
            end
            w.ctrl = 8'h00;
        end else if (locked) begin
            case (p[7:0])
                8'h1e: lanes = '{default: `PCS_XGMII_IDLE};
                8'h78: begin
                    lanes[0] = `PCS_XGMII_START;
                    for (int i = 1; i < 8; i++) begin
                        lanes[i] = p[8*i +: 8];
                    end
                    w.ctrl = 8'h01;
                end
                8'h87: begin
                    lanes = '{default: `PCS_XGMII_IDLE};
                    lanes[0] = `PCS_XGMII_TERM;
                end
                8'hff: begin
                    for (int i = 0; i < 7; i++) begin
                        lanes[i] = p[8*i+8 +: 8];
                    end
                    lanes[7] = `PCS_XGMII_TERM;
                    w.ctrl = 8'h80;
                end
                default: ;
            endcase
        end
        for (int i = 0; i < 8; i++) begin
            w.data[8*i +: 8] = lanes[i];
        end
        w.valid = 1'b1;
        return w;
    endfunction

    task automatic send_block(input sync_hdr_t hdr, input blk_payload_t plain,
                              input logic locked);
        blk_payload_t scr;
        xgmii_word_t exp;
        scramble(plain, scr);
        exp = decode_expect(hdr, plain, locked);
        @(posedge gt_rxusrclk);
        gt_rx <= '{hdr: hdr, payload: scr, valid: 1'b1};
        // Counter is still one behind here
        // Word leaves two edges later
        exp_q.push_back(exp);
        due_q.push_back(cyc + 3);
        win_pos++;
        if (exp.ctrl == 8'hff && exp.data == {8{`PCS_XGMII_ERROR}}) begin
            exp_errors++;
        end
    endtask

    task automatic send_gap(input int n);
        repeat (n) begin
            @(posedge gt_rxusrclk);
            gt_rx.valid <= 1'b0;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            @(posedge gt_rxusrclk);
            n++;
        end
        if (exp_q.size() != 0) begin
            fail_now("expected XGMII words never appeared");
        end
    endtask

    task automatic wait_slip();
        int n;
        n = 0;
        do begin
            @(negedge gt_rxusrclk);
            n++;
        end while (gearbox_slip !== 1'b1 && n < 100);
        if (gearbox_slip !== 1'b1) begin
            fail_now("no gearbox_slip pulse within the timeout");
        end
        // Pulse lasts one cycle
        @(negedge gt_rxusrclk);
        check_bit("gearbox_slip", gearbox_slip, 1'b0);
    endtask

    // Scoreboard checking order and latency of every XGMII word
    always @(negedge gt_rxusrclk) begin
        if (!gt_tx_reset && xgmii.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                fail_now("an XGMII word appeared with none expected");
            end else begin
                if (cyc != due_q[0]) begin
                    fail_now($sformatf("XGMII word came out at cycle %0d, not %0d",
                                       cyc, due_q[0]));
                end
                check_xgmii("xgmii", xgmii, exp_q[0]);
                exp_q.delete(0);
                due_q.delete(0);
            end
        end
    end

    initial begin
        blk_payload_t p;
        err_count_t count_before;
        int n;
        gt_rx = '0;
        cyc = 0;
        win_pos = 0;
        exp_errors = 0;
        rng_state = 32'h36b4;
        tx_hist = '0;

        // Reset state
        n = 0;
        do begin
            @(posedge gt_rxusrclk);
            n++;
        end while (gt_tx_reset !== 1'b0 && n < 20);
        if (gt_tx_reset !== 1'b0) begin
            fail_now("reset was never released");
        end
        @(negedge gt_rxusrclk);
        check_bit("block_lock", block_lock, 1'b0);
        check_bit("gearbox_slip", gearbox_slip, 1'b0);
        check_bit("xgmii.valid", xgmii.valid, 1'b0);
        check_count("error_count", error_count, '0);

        // Slip on a bad header and then acquire lock on idles
        rand64(p);
        send_block(2'b00, p, 1'b0);
        send_gap(1);
        wait_slip();
        for (int i = 0; i < `PCS_SLIP_WAIT + `PCS_LOCK_GOOD_CNT; i++) begin
            rand64(p);
            send_block(2'b10, {p[63:8], 8'h1e},
                       i == `PCS_SLIP_WAIT + `PCS_LOCK_GOOD_CNT - 1);
        end
        win_pos = 0;
        send_gap(1);
        drain();
        check_bit("block_lock", block_lock, 1'b1);
        check_count("error_count", error_count, err_count_t'(exp_errors));

        // Data blocks with random gaps
        for (int i = 0; i < 40; i++) begin
            rng_state = xorshift32(rng_state);
            send_gap(rng_state % 3);
            rand64(p);
            send_block(2'b01, p, 1'b1);
        end
        send_gap(1);
        drain();

        // Supported control blocks
        for (int i = 0; i < 16; i++) begin
            rand64(p);
            send_block(2'b10, {p[63:8], ctrl_types[i % 4]}, 1'b1);
        end
        send_gap(1);
        drain();

        // Unsupported block types
        count_before = error_count;
        n = 0;
        while (n < 6) begin
            rand64(p);
            if (!(p[7:0] inside {8'h1e, 8'h78, 8'h87, 8'hff})) begin
                send_block(2'b10, p, 1'b1);
                n++;
            end
        end
        send_gap(1);
        drain();
        check_count("error_count", error_count, count_before + 16'd6);

        // Loss of lock from bad headers at the start of a window
        count_before = error_count;
        repeat ((`PCS_LOCK_WINDOW - win_pos % `PCS_LOCK_WINDOW) % `PCS_LOCK_WINDOW) begin
            rand64(p);
            send_block(2'b10, {p[63:8], 8'h1e}, 1'b1);
        end
        for (int i = 0; i < `PCS_LOCK_BAD_MAX; i++) begin
            rand64(p);
            send_block(2'b00, {p[63:8], 8'h1e}, i < `PCS_LOCK_BAD_MAX - 1);
        end
        send_gap(1);
        wait_slip();
        check_bit("block_lock", block_lock, 1'b0);
        drain();
        check_count("error_count", error_count, count_before + 16'd1);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: flist.f
+incdir+rtl
rtl/pcs_pkg.sv
rtl/rx_block_lock.sv
rtl/rx_descrambler.sv
rtl/rx_block_decoder.sv
rtl/sfp_rx_pcs.sv
dv/tb_clk_gen.sv
dv/sfp_rx_pcs_tb.sv
